// ==== hdl/stream_pkg.sv ====
`default_nettype none

package stream_pkg;

    ////////////////////
    // Input beat geometry
    ////////////////////

    localparam int BEAT_BYTES  = 8;                  // Bytes per 64-bit beat
    localparam int EMPTY_W     = 3;                  // Width of in_empty
    localparam int COUNT_BYTES = 2;                  // Message count field at payload start

    // Head view of the start beat
    typedef struct packed {
        logic [COUNT_BYTES*8-1:0]              msg_count;  // Big-endian count
        logic [(BEAT_BYTES-COUNT_BYTES)*8-1:0] rest;       // First payload bytes after count
    } beat_head_t;

    // One beat, read as bytes or as a head
    typedef union packed {
        logic [0:BEAT_BYTES-1][7:0] bytes;           // bytes[0] is bits 63:56
        beat_head_t                 head;            // Only meaningful on the start beat
    } beat_u;

endpackage

`default_nettype wire

// ==== hdl/msg_pkg.sv ====
`default_nettype none

package msg_pkg;

    ////////////////////
    // Message framing
    ////////////////////

    localparam int LEN_BYTES     = 2;                // Length field ahead of every body
    localparam int MIN_MSG_BYTES = 8;                // Shortest legal body
    localparam int MAX_MSG_BYTES = 32;               // Longest legal body

    ////////////////////
    // Output word
    ////////////////////

    localparam int OUT_W  = 256;                     // out_data width, 32 byte lanes
    localparam int MASK_W = 32;                      // One mask bit per lane

    // Width able to hold 0..MAX_MSG_BYTES
    localparam int LEN_W = $clog2(MAX_MSG_BYTES + 1);

endpackage

`default_nettype wire

// ==== hdl/byte_window_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Byte window handed from the unpacker to the field parser
interface byte_window_if #(
    parameter int WINDOW_BYTES = 16
);
    localparam int FILL_W = $clog2(WINDOW_BYTES + 1);

    logic [0:WINDOW_BYTES-1][7:0] window;            // Oldest byte at index 0
    logic [FILL_W-1:0]            fill;              // Valid bytes in window
    logic [15:0]                  msg_count;         // Count of current payload
    logic                         start;             // Pulse, new count captured
    logic                         drained;           // Payload ended and window empty
    logic [FILL_W-1:0]            take;              // Bytes consumed this cycle

    modport unpacker (output window, fill, msg_count, start, drained, input take);
    modport parser   (input window, fill, msg_count, start, drained, output take);

endinterface

`default_nettype wire

// ==== hdl/msg_frag_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Body chunks from the parser to the assembler, no back-pressure
interface msg_frag_if #(
    parameter int WINDOW_BYTES = 16
);
    import stream_pkg::*;
    import msg_pkg::*;

    logic [0:BEAT_BYTES-1][7:0]          chunk;        // chunk[0] is the lowest message byte
    logic [$clog2(WINDOW_BYTES+1)-1:0]   chunk_bytes;  // Sized like take, a chunk never exceeds it
    logic [LEN_W-1:0]                    offset;       // Byte position in message
    logic [LEN_W-1:0]                    msg_len;      // Whole message length
    logic                                first;        // First chunk of message
    logic                                last;         // Final chunk of message
    logic                                frag_valid;

    modport parser    (output chunk, chunk_bytes, offset, msg_len, first, last, frag_valid);
    modport assembler (input chunk, chunk_bytes, offset, msg_len, first, last, frag_valid);

endinterface

`default_nettype wire

// ==== hdl/beat_unpacker.sv ====
`timescale 1ns/100ps
`default_nettype none

module beat_unpacker #(
    parameter int WINDOW_BYTES = 16
) (
    input  wire logic                           clk,
    input  wire logic                           reset_n,
    input  wire logic                           in_valid,
    input  wire logic                           in_startofpayload,
    input  wire logic                           in_endofpayload,
    input  wire stream_pkg::beat_u              in_data,
    input  wire logic [stream_pkg::EMPTY_W-1:0] in_empty,
    output logic                                in_ready,
    byte_window_if.unpacker                     win
);
    import stream_pkg::*;

    localparam int FILL_W = $clog2(WINDOW_BYTES + 1);

    logic [0:WINDOW_BYTES-1][7:0] window, window_next;
    logic [FILL_W-1:0]            fill, fill_next;
    logic                         end_seen, end_next;   // End beat taken, padding may remain
    logic                         drained;
    logic                         ready_en;             // Holds in_ready off one extra cycle
    logic                         ready_next;

    // Start beat that arrived before the previous payload drained
    beat_u                        pend_data;
    logic                         pend_valid, pend_next;
    logic                         pend_eop;
    logic [EMPTY_W-1:0]           pend_empty;

    // Beat source for this cycle, either the port or the parked start beat
    logic                         use_pend, stash, src_valid, src_sop, src_eop;
    beat_u                        src_beat;
    logic [EMPTY_W-1:0]           src_empty;

    assign drained  = end_seen && (fill == '0);
    assign use_pend = pend_valid && drained;
    // A start beat may only clear the window once the old payload is gone
    assign stash    = in_valid && in_startofpayload && end_seen && !drained;

    assign src_valid = use_pend || (in_valid && !stash);
    assign src_beat  = use_pend ? pend_data  : in_data;
    assign src_sop   = use_pend ? 1'b1       : in_startofpayload;
    assign src_eop   = use_pend ? pend_eop   : in_endofpayload;
    assign src_empty = use_pend ? pend_empty : in_empty;

    ////////////////////
    // Window shift and append
    ////////////////////

    always_comb
    begin
        int n_new;                                   // Valid bytes brought by the beat
        int kept;                                    // Old bytes left after take
        int skip;                                    // Count bytes skipped on start beat
        int room;

        n_new = src_eop ? (BEAT_BYTES - int'(src_empty)) : BEAT_BYTES;
        skip  = src_sop ? COUNT_BYTES : 0;
        n_new = n_new - skip;
        if (n_new < 0)
            n_new = 0;                               // Malformed tiny payload
        if (!src_valid)
            n_new = 0;
        kept = (src_valid && src_sop) ? 0 : int'(fill) - int'(win.take);

        for (int i = 0; i < WINDOW_BYTES; i++)
        begin
            if (i + int'(win.take) < WINDOW_BYTES)
                window_next[i] = window[i + int'(win.take)];
            else
                window_next[i] = 8'h00;
        end
        for (int i = 0; i < BEAT_BYTES; i++)
        begin
            if (i < n_new && kept + i < WINDOW_BYTES)
                window_next[kept + i] = src_beat.bytes[skip + i];
        end

        fill_next = FILL_W'(kept + n_new);
        if (src_valid)
            end_next = src_sop ? src_eop : (end_seen | src_eop);
        else
            end_next = end_seen;
        pend_next = use_pend ? 1'b0 : (stash | pend_valid);

        // One beat may already be in flight when in_ready is high now
        room       = WINDOW_BYTES - int'(fill_next);
        ready_next = ready_en && !pend_next && !(end_next && fill_next != '0) &&
                     (room >= BEAT_BYTES + (in_ready ? BEAT_BYTES : 0));
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            fill       <= '0;
            end_seen   <= 1'b0;
            pend_valid <= 1'b0;
            win.start  <= 1'b0;
            ready_en   <= 1'b0;
            in_ready   <= 1'b0;
        end
        else
        begin
            fill       <= fill_next;
            end_seen   <= end_next;
            pend_valid <= pend_next;
            win.start  <= src_valid && src_sop;      // Count valid from next cycle
            ready_en   <= 1'b1;
            in_ready   <= ready_next;
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        window <= window_next;
        if (src_valid && src_sop)
            win.msg_count <= src_beat.head.msg_count;
        if (stash)
        begin
            pend_data  <= in_data;
            pend_eop   <= in_endofpayload;
            pend_empty <= in_empty;
        end
    end

    assign win.window  = window;
    assign win.fill    = fill;
    assign win.drained = drained;

endmodule

`default_nettype wire

// ==== hdl/field_parser.sv ====
`timescale 1ns/100ps
`default_nettype none

module field_parser (
    input  wire logic   clk,
    input  wire logic   reset_n,
    byte_window_if.parser win,
    msg_frag_if.parser  frag
);
    import stream_pkg::*;
    import msg_pkg::*;

    localparam int FILL_W = $bits(win.fill);

    typedef enum logic [1:0] {
        IDLE   = 2'd0,                               // Waiting for a count
        LENGTH = 2'd1,                               // Reading a 2-byte length
        BODY   = 2'd2,                               // Sending body chunks
        SKIP   = 2'd3                                // Dropping trailing padding
    } state_t;

    state_t           state;
    logic [15:0]      msgs_left;                     // Messages not yet started
    logic [LEN_W-1:0] cur_len;
    logic [LEN_W-1:0] body_off;                      // Bytes of body already sent
    logic [15:0]      len_field;
    logic [FILL_W-1:0] need;                         // Bytes this state wants
    logic             have;                          // Enough bytes in window
    logic             last_chunk;

    assign len_field = {win.window[0], win.window[1]};  // Big-endian length

    ////////////////////
    // Field sizing
    ////////////////////

    always_comb
    begin
        int remain;

        remain = int'(cur_len) - int'(body_off);
        if (state == LENGTH)
            need = FILL_W'(LEN_BYTES);
        else if (remain > BEAT_BYTES)
            need = FILL_W'(BEAT_BYTES);              // Full chunk
        else
            need = FILL_W'(remain);                  // Tail of body
    end

    assign have       = (win.fill >= need);
    assign last_chunk = (int'(body_off) + int'(need) == int'(cur_len));

    always_comb
    begin
        case (state)
            LENGTH:  win.take = have ? need : '0;
            BODY:    win.take = have ? need : '0;
            SKIP:    win.take = win.start ? '0 : win.fill;  // Never eat a new payload
            default: win.take = '0;
        endcase
    end

    // Chunk straight off the front of the window
    always_comb
    begin
        for (int i = 0; i < BEAT_BYTES; i++)
            frag.chunk[i] = win.window[i];
    end

    assign frag.chunk_bytes = need;
    assign frag.offset      = body_off;
    assign frag.msg_len     = cur_len;
    assign frag.first       = (body_off == '0);
    assign frag.last        = last_chunk;
    assign frag.frag_valid  = (state == BODY) && have;

    ////////////////////
    // FSM
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state     <= IDLE;
            msgs_left <= '0;
            cur_len   <= '0;
            body_off  <= '0;
        end
        else
        begin
            case (state)
                IDLE, SKIP:
                begin
                    if (win.start)
                    begin
                        msgs_left <= win.msg_count;
                        state     <= (win.msg_count == '0) ? SKIP : LENGTH;
                    end
                    else if (state == SKIP && win.drained)
                        state <= IDLE;               // Payload fully consumed
                end
                LENGTH:
                begin
                    if (have)
                    begin
                        cur_len   <= len_field[LEN_W-1:0];  // Range 8..32 by input rules
                        body_off  <= '0;
                        msgs_left <= msgs_left - 16'd1;
                        state     <= BODY;
                    end
                    else if (win.drained)
                        state <= IDLE;               // Truncated payload
                end
                BODY:
                begin
                    if (have)
                    begin
                        body_off <= body_off + LEN_W'(need);
                        if (last_chunk)
                            state <= (msgs_left == '0) ? SKIP : LENGTH;
                    end
                    else if (win.drained)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/msg_assembler.sv ====
`timescale 1ns/100ps
`default_nettype none

module msg_assembler (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    msg_frag_if.assembler               frag,
    output logic [msg_pkg::OUT_W-1:0]   out_data,
    output logic [msg_pkg::MASK_W-1:0]  out_bytemask,
    output logic                        out_valid
);
    import stream_pkg::*;
    import msg_pkg::*;

    logic [MAX_MSG_BYTES-1:0][7:0] acc;              // acc[k] is lane k
    logic [MAX_MSG_BYTES-1:0][7:0] acc_next;
    logic [MASK_W:0]               mask_wide;        // One spare bit for a 32-byte mask

    // Merge the chunk into its lanes
    always_comb
    begin
        int lane;

        acc_next = frag.first ? '0 : acc;            // New message starts clean
        for (int i = 0; i < BEAT_BYTES; i++)
        begin
            lane = int'(frag.offset) + i;
            if (i < int'(frag.chunk_bytes) && lane < MAX_MSG_BYTES)
                acc_next[lane] = frag.chunk[i];
        end
    end

    assign mask_wide = ((MASK_W+1)'(1) << frag.msg_len) - (MASK_W+1)'(1);

    always_ff @(posedge clk)
    begin
        if (frag.frag_valid)
            acc <= acc_next;
    end

    ////////////////////
    // Output pulse
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            out_valid    <= 1'b0;
            out_data     <= '0;
            out_bytemask <= '0;
        end
        else if (frag.frag_valid && frag.last)
        begin
            out_valid    <= 1'b1;
            out_data     <= OUT_W'(acc_next);
            out_bytemask <= mask_wide[MASK_W-1:0];   // msg_len low ones
        end
        else
        begin
            out_valid    <= 1'b0;                    // Idle outputs read zero
            out_data     <= '0;
            out_bytemask <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/msg_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module msg_decoder (
    input  wire logic                               clk,
    input  wire logic                               reset_n,
    input  wire logic                               in_valid,
    input  wire logic                               in_startofpayload,
    input  wire logic                               in_endofpayload,
    output logic                                    in_ready,
    input  wire logic [stream_pkg::BEAT_BYTES*8-1:0] in_data,
    input  wire logic [stream_pkg::EMPTY_W-1:0]     in_empty,
    input  wire logic                               in_error,   // Assumed always 0
    output logic [msg_pkg::OUT_W-1:0]               out_data,
    output logic                                    out_valid,
    output logic [msg_pkg::MASK_W-1:0]              out_bytemask
);
    localparam int WINDOW_BYTES = 16;                // Two beats of buffering

    byte_window_if #(.WINDOW_BYTES(WINDOW_BYTES)) u_win ();
    msg_frag_if    #(.WINDOW_BYTES(WINDOW_BYTES)) u_frag ();

    // Beats into a byte window
    beat_unpacker #(
        .WINDOW_BYTES (WINDOW_BYTES)
    ) u_unpacker (
        .clk               (clk),
        .reset_n           (reset_n),
        .in_valid          (in_valid),
        .in_startofpayload (in_startofpayload),
        .in_endofpayload   (in_endofpayload),
        .in_data           (in_data),
        .in_empty          (in_empty),
        .in_ready          (in_ready),
        .win               (u_win.unpacker)
    );

    // Lengths and bodies out of the window
    field_parser u_parser (
        .clk     (clk),
        .reset_n (reset_n),
        .win     (u_win.parser),
        .frag    (u_frag.parser)
    );

    // Chunks into one output word per message
    msg_assembler u_assembler (
        .clk          (clk),
        .reset_n      (reset_n),
        .frag         (u_frag.assembler),
        .out_data     (out_data),
        .out_bytemask (out_bytemask),
        .out_valid    (out_valid)
    );

endmodule

`default_nettype wire

// ==== bench/msg_decoder_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module msg_decoder_props (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    input  wire logic                      in_ready,
    input  wire logic                      out_valid,
    input  wire logic [msg_pkg::OUT_W-1:0]  out_data,
    input  wire logic [msg_pkg::MASK_W-1:0] out_bytemask
);
    import msg_pkg::*;

    int pulse_fails = 0;
    int mask_fails  = 0;
    int idle_fails  = 0;
    int reset_fails = 0;
    int fail_count;

    assign fail_count = pulse_fails + mask_fails + idle_fails + reset_fails;

    ////////////////////
    // Output framing
    ////////////////////

    a_one_cycle_pulse: assert property (@(posedge clk) disable iff (reset_n)
        out_valid |=> !out_valid)
    else
    begin
        $error("out_valid high for two cycles in a row");
        pulse_fails++;
    end

    // Contiguous low ones, 8 to 32 of them
    a_mask_shape: assert property (@(posedge clk) disable iff (reset_n)
        out_valid |-> ((out_bytemask & (out_bytemask + MASK_W'(1))) == '0) &&
                      ($countones(out_bytemask) >= MIN_MSG_BYTES) &&
                      ($countones(out_bytemask) <= MAX_MSG_BYTES))
    else
    begin
        $error("out_bytemask not a run of 8 to 32 low ones");
        mask_fails++;
    end

    a_idle_zero: assert property (@(posedge clk) disable iff (reset_n)
        !out_valid |-> (out_data == '0) && (out_bytemask == '0))
    else
    begin
        $error("out_data or out_bytemask nonzero without out_valid");
        idle_fails++;
    end

    // First cycle of reset may still show the power-up value
    a_ready_in_reset: assert property (@(posedge clk)
        reset_n && $past(reset_n) |-> !in_ready)
    else
    begin
        $error("in_ready high during reset");
        reset_fails++;
    end

endmodule

`default_nettype wire

// ==== bench/msg_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module msg_checker (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    input  wire logic                      in_valid,
    input  wire logic                      in_ready,
    input  wire logic [msg_pkg::OUT_W-1:0]  out_data,
    input  wire logic [msg_pkg::MASK_W-1:0] out_bytemask,
    input  wire logic                      out_valid,
    input  wire logic                      done,
    output int                             errors,
    output int                             pending,
    output int                             seen
);
    import msg_pkg::*;

    logic [OUT_W-1:0]  exp_data_q [$];               // Expected messages, payload order
    logic [MASK_W-1:0] exp_mask_q [$];
    logic [OUT_W-1:0]  want_data;
    logic [MASK_W-1:0] want_mask;
    logic              ready_last = 1'b0;            // in_ready one cycle back
    logic              done_seen  = 1'b0;
    int                err_count  = 0;
    int                msg_count  = 0;

    assign errors  = err_count;
    assign pending = exp_data_q.size();
    assign seen    = msg_count;

    task automatic expect_msg(input logic [OUT_W-1:0] data, input logic [MASK_W-1:0] mask);
        exp_data_q.push_back(data);
        exp_mask_q.push_back(mask);
    endtask

    ////////////////////
    // Compare at negedge, all DUT outputs settled
    ////////////////////

    always @(negedge clk)
    begin
        if (!reset_n)
        begin
            if (in_valid && !ready_last)             // Source broke latency 1
            begin
                err_count++;
                $display("error %0t: beat sent while in_ready was low a cycle earlier", $time);
            end
            if (out_valid)
            begin
                if (exp_data_q.size() == 0)
                begin
                    err_count++;
                    $display("error %0t: message out with none expected, mask %h",
                             $time, out_bytemask);
                end
                else
                begin
                    want_data = exp_data_q.pop_front();
                    want_mask = exp_mask_q.pop_front();
                    if (out_data !== want_data || out_bytemask !== want_mask)
                    begin
                        err_count++;
                        $display("error %0t: message %0d got data %h mask %h", $time,
                                 msg_count, out_data, out_bytemask);
                        $display("    expected data %h mask %h", want_data, want_mask);
                    end
                    msg_count++;
                end
            end
        end
        if (done && !done_seen)
        begin
            done_seen = 1'b1;
            if (exp_data_q.size() != 0)              // Messages that never came out
            begin
                err_count += exp_data_q.size();
                $display("%0d expected messages never came out of the decoder",
                         exp_data_q.size());
            end
        end
        ready_last = in_ready;
    end

endmodule

`default_nettype wire

// ==== bench/tb_msg_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_msg_decoder;
    import stream_pkg::*;
    import msg_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;                // Inputs change this long after the edge
    localparam int RESET_CYCLES = 16;
    localparam int N_PAY        = 11;
    localparam int MAX_MSGS     = 4;
    localparam int PASSES       = 2;                 // Table applied twice, fresh LFSR data
    localparam int DRAIN_CYCLES = 200;               // Wait for the last messages

    logic                    clk;
    logic                    reset_n;
    logic                    in_valid;
    logic                    in_startofpayload;
    logic                    in_endofpayload;
    logic                    in_ready;
    logic [BEAT_BYTES*8-1:0] in_data;
    logic [EMPTY_W-1:0]      in_empty;
    logic                    in_error;
    logic [OUT_W-1:0]        out_data;
    logic                    out_valid;
    logic [MASK_W-1:0]       out_bytemask;
    logic                    done;
    int                      chk_errors;
    int                      chk_pending;
    int                      chk_seen;
    int                      tb_errors;
    logic                    ready_now;              // in_ready in the current cycle
    logic                    ready_seen;             // in_ready one cycle earlier
    logic [31:0]             lfsr_state = 32'h24d1681a;

    ////////////////////
    // Stimulus table
    ////////////////////

    // Message count, lengths, padding after last message, messages expected out
    int tbl_count [N_PAY] = '{1, 1, 3, 0, 2, 2, 1, 4, 0, 2, 1};
    int tbl_len [N_PAY][MAX_MSGS] = '{
        '{ 8,  0,  0,  0},                           // Shortest message, empty 4
        '{32,  0,  0,  0},                           // Longest message, empty 2
        '{ 8, 17, 32,  0},                           // Mixed, length split at byte 31/32
        '{ 0,  0,  0,  0},                           // Count zero, single beat
        '{11,  9,  0,  0},                           // Length field split at byte 15/16
        '{20, 13,  0,  0},                           // empty 1
        '{15,  0,  0,  0},                           // empty 7
        '{ 8,  8,  8,  8},                           // empty 3
        '{ 0,  0,  0,  0},                           // Count zero with two beats of padding
        '{32, 31,  0,  0},                           // empty 3
        '{10,  0,  0,  0}                            // empty 2
    };
    int tbl_pad [N_PAY]      = '{0, 2, 7, 0, 1, 0, 6, 3, 9, 0, 0};
    int tbl_exp_msgs [N_PAY] = '{1, 1, 3, 0, 2, 2, 1, 4, 0, 2, 1};

    msg_decoder u_dut (
        .clk               (clk),
        .reset_n           (reset_n),
        .in_valid          (in_valid),
        .in_startofpayload (in_startofpayload),
        .in_endofpayload   (in_endofpayload),
        .in_ready          (in_ready),
        .in_data           (in_data),
        .in_empty          (in_empty),
        .in_error          (in_error),
        .out_data          (out_data),
        .out_valid         (out_valid),
        .out_bytemask      (out_bytemask)
    );

    msg_checker u_checker (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_data     (out_data),
        .out_bytemask (out_bytemask),
        .out_valid    (out_valid),
        .done         (done),
        .errors       (chk_errors),
        .pending      (chk_pending),
        .seen         (chk_seen)
    );

    bind msg_decoder msg_decoder_props u_props (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_bytemask (out_bytemask)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Right-shift Galois LFSR
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit, first bit ends up as the MSB
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            v          = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic int payload_bytes(input int idx);
        int total;
        total = COUNT_BYTES;
        for (int m = 0; m < tbl_count[idx]; m++)
            total += LEN_BYTES + tbl_len[idx][m];
        return total + tbl_pad[idx];
    endfunction

    // Move to the drive point of the next cycle, track in_ready history
    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
        ready_seen = ready_now;
        ready_now  = in_ready;
    endtask

    task automatic idle_cycle();
        in_valid          = 1'b0;
        in_startofpayload = 1'b0;
        in_endofpayload   = 1'b0;
        in_empty          = '0;
        in_data           = '0;
        tick();
    endtask

    task automatic send_beat(input logic [63:0] data, input logic sop, input logic eop,
                             input logic [EMPTY_W-1:0] empty);
        int stall;
        stall = 0;
        if (rand_bits(2) == 0)
            stall = 1 + rand_bits(2);                // Random gap of 1..4 cycles
        repeat (stall) idle_cycle();
        while (!ready_seen)                          // Latency 1, look one cycle back
            idle_cycle();
        in_valid          = 1'b1;
        in_data           = data;
        in_startofpayload = sop;
        in_endofpayload   = eop;
        in_empty          = eop ? empty : '0;
        tick();
    endtask

    // Build one payload, queue its messages, send its beats
    task automatic run_payload(input int idx);
        logic [7:0]        pl [$];
        logic [OUT_W-1:0]  exp_data;
        logic [MASK_W-1:0] exp_mask;
        logic [7:0]        b;
        logic [63:0]       beat;
        int                n, len, total, beats, empty, gap, pos;
        n = tbl_count[idx];
        pl.push_back(n[15:8]);                       // Big-endian count
        pl.push_back(n[7:0]);
        for (int m = 0; m < n; m++)
        begin
            len = tbl_len[idx][m];
            pl.push_back(len[15:8]);
            pl.push_back(len[7:0]);
            exp_data = '0;
            exp_mask = '0;
            for (int k = 0; k < len; k++)
            begin
                b = 8'(rand_bits(8));
                pl.push_back(b);
                exp_data[8*k +: 8] = b;              // Byte k in lane k
                exp_mask[k]        = 1'b1;
            end
            u_checker.expect_msg(exp_data, exp_mask);
        end
        for (int p = 0; p < tbl_pad[idx]; p++)
            pl.push_back(8'(rand_bits(8)));          // Padding, must be dropped
        total = pl.size();
        beats = (total + BEAT_BYTES - 1) / BEAT_BYTES;
        empty = beats * BEAT_BYTES - total;
        gap   = rand_bits(2);                        // Zero means back to back
        repeat (gap) idle_cycle();
        for (int bt = 0; bt < beats; bt++)
        begin
            for (int j = 0; j < BEAT_BYTES; j++)
            begin
                pos = bt * BEAT_BYTES + j;
                b   = (pos < total) ? pl[pos] : 8'(rand_bits(8));  // Unused bytes are junk
                beat[63 - 8*j -: 8] = b;             // Byte 0 is bits 63:56
            end
            send_beat(beat, bt == 0, bt == beats - 1, empty[EMPTY_W-1:0]);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        int drain;
        int exp_total;
        int prop_errors;
        int total;
        reset_n           = 1'b1;
        in_valid          = 1'b0;
        in_startofpayload = 1'b0;
        in_endofpayload   = 1'b0;
        in_data           = '0;
        in_empty          = '0;
        in_error          = 1'b0;                    // Never used by the decoder
        done              = 1'b0;
        tb_errors         = 0;
        ready_now         = 1'b0;
        ready_seen        = 1'b0;
        exp_total         = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b0;
        for (int r = 0; r < PASSES; r++)
        begin
            for (int i = 0; i < N_PAY; i++)
            begin
                run_payload(i);
                exp_total += tbl_exp_msgs[i];
            end
        end
        idle_cycle();
        drain = 0;
        while (chk_pending != 0 && drain < DRAIN_CYCLES)
        begin
            tick();
            drain++;
        end
        repeat (10) tick();                          // Room for stray extra messages
        if (chk_seen != exp_total)
        begin
            tb_errors++;
            $display("error %0t: %0d messages decoded, table expects %0d",
                     $time, chk_seen, exp_total);
        end
        done = 1'b1;
        tick();
        tick();
        prop_errors = u_dut.u_props.fail_count;
        total       = chk_errors + prop_errors + tb_errors;
        $display("closing counts: checker %0d, assertions %0d, bench %0d, total %0d",
                 chk_errors, prop_errors, tb_errors, total);
        if (total == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog, 40 cycles per beat of the table plus a fixed margin
    initial
    begin
        int budget;
        budget = RESET_CYCLES + 200;
        for (int r = 0; r < PASSES; r++)
            for (int i = 0; i < N_PAY; i++)
                budget += 40 * ((payload_bytes(i) + BEAT_BYTES - 1) / BEAT_BYTES);
        repeat (budget) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", budget);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/stream_pkg.sv
hdl/msg_pkg.sv
hdl/byte_window_if.sv
hdl/msg_frag_if.sv
hdl/beat_unpacker.sv
hdl/field_parser.sv
hdl/msg_assembler.sv
hdl/msg_decoder.sv
bench/msg_decoder_props.sv
bench/msg_checker.sv
bench/tb_msg_decoder.sv

// ==== Makefile ====
# Verilator simulation of the message decoder

VERILATOR ?= verilator
TOP       ?= tb_msg_decoder
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
